// ==== run_sim.sh ====
#!/bin/sh
# Build the vector ALU testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module vv_alu_tb \
  -f src.f -o vv_alu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/vv_alu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

// ==== source/vv_alu_datapath.sv ====
//------------------
// ALU datapath
// Stage register, operand forwarding, lane arithmetic,
// frame condition gating and register file write-back
//------------------

module vv_alu_datapath (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              tracing,
  input  vv_data_pkg::vv_beat_t             beat_in,
  input  vv_firmware_pkg::firmware_entry_t  entry,
  output vv_data_pkg::rf_addr_t             rf_rd_addr,
  input  vv_data_pkg::vector_t              rf_rd_data,
  output logic                              rf_wr_en,
  output vv_data_pkg::rf_addr_t             rf_wr_addr,
  output vv_data_pkg::vector_t              rf_wr_data,
  output vv_data_pkg::vv_beat_t             beat_out
);

  // Stage register, item waiting for its operand
  logic                             stage_valid;
  logic [vv_data_pkg::chain_bits-1:0] stage_chain;
  vv_data_pkg::frame_flags_t        stage_flags;
  vv_data_pkg::vector_t             stage_data;
  vv_firmware_pkg::firmware_entry_t stage_entry;

  // What the item one ahead wrote back
  logic                  prev_wr_en;
  vv_data_pkg::rf_addr_t prev_wr_addr;

  logic                 forward;
  logic                 cond_ok;
  vv_data_pkg::vector_t operand;
  vv_data_pkg::vector_t add_v;
  vv_data_pkg::vector_t mul_v;
  vv_data_pkg::vector_t sub_v;
  vv_data_pkg::vector_t max_v;
  vv_data_pkg::vector_t alu_v;
  vv_data_pkg::vector_t result_v;

  function automatic logic cond_holds(vv_firmware_pkg::vv_cond_e cond,
                                      vv_data_pkg::frame_flags_t flags);
    case (cond)
      vv_firmware_pkg::cond_none:            return 1'b1;
      vv_firmware_pkg::cond_last:            return flags.eof[0];
      vv_firmware_pkg::cond_not_last:        return !flags.eof[0];
      vv_firmware_pkg::cond_first:           return flags.bof[0];
      vv_firmware_pkg::cond_not_first:       return !flags.bof[0];
      vv_firmware_pkg::cond_outer_last:      return flags.eof[1];
      vv_firmware_pkg::cond_outer_not_last:  return !flags.eof[1];
      vv_firmware_pkg::cond_outer_first:     return flags.bof[1];
      vv_firmware_pkg::cond_outer_not_first: return !flags.bof[1];
      default:                               return 1'b0;
    endcase
  endfunction

  // Read issued in the same cycle as the lookup
  assign rf_rd_addr = entry.addr_rd;

  //------------------
  // Stage register
  //------------------
  always_ff @(posedge clk) begin
    stage_chain  <= beat_in.chain_id;
    stage_flags  <= beat_in.flags;
    stage_data   <= beat_in.data;
    stage_entry  <= entry;
    prev_wr_addr <= rf_wr_addr;
    if (reset) begin
      stage_valid <= 1'b0;
      prev_wr_en  <= 1'b0;
    end else begin
      stage_valid <= beat_in.valid && tracing;
      prev_wr_en  <= rf_wr_en;
    end
  end

  //------------------
  // Lane arithmetic
  //------------------
  // The register file still holds the old value for a back-to-back hit
  assign forward = prev_wr_en && (prev_wr_addr == stage_entry.addr_rd);
  assign operand = forward ? beat_out.data : rf_rd_data;
  assign cond_ok = cond_holds(stage_entry.cond, stage_flags);

  always_comb begin
    for (int i = 0; i < vv_data_pkg::lanes; i++) begin
      add_v[i] = stage_data[i] + operand[i];
      mul_v[i] = stage_data[i] * operand[i];
      sub_v[i] = stage_data[i] - operand[i];
      max_v[i] = (stage_data[i] > operand[i]) ? stage_data[i] : operand[i];
    end
    case (stage_entry.op)
      vv_firmware_pkg::op_pass: alu_v = stage_data;
      vv_firmware_pkg::op_add:  alu_v = add_v;
      vv_firmware_pkg::op_mul:  alu_v = mul_v;
      vv_firmware_pkg::op_sub:  alu_v = sub_v;
      default:                  alu_v = max_v;
    endcase
    result_v = cond_ok ? alu_v : stage_data;
  end

  // Write-back lands on the same edge as the output register
  assign rf_wr_en   = stage_valid && stage_entry.cache;
  assign rf_wr_addr = stage_entry.cache_addr;
  assign rf_wr_data = result_v;

  //------------------
  // Output register
  //------------------
  always_ff @(posedge clk) begin
    beat_out.chain_id <= stage_chain;
    beat_out.flags    <= stage_flags;
    beat_out.data     <= result_v;
    if (reset) begin
      beat_out.valid <= 1'b0;
    end else begin
      beat_out.valid <= stage_valid && tracing;
    end
  end

  // No beat leaves right after reset
  assert property (@(posedge clk) reset |=> !beat_out.valid);

endmodule

// ==== source/vv_alu_top.sv ====
//------------------
// Vector-vector ALU stage
// Firmware store, register file and datapath for a
// two-cycle streaming vector operation
//------------------

module vv_alu_top #(
  parameter logic [7:0] config_unit_id = 8'd0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  tracing,
  input  logic [7:0]            config_id,
  input  logic [7:0]            config_data,
  input  vv_data_pkg::vv_beat_t beat_in,
  output vv_data_pkg::vv_beat_t beat_out
);

  vv_firmware_pkg::firmware_entry_t entry;

  vv_data_pkg::rf_addr_t rf_rd_addr;
  vv_data_pkg::vector_t  rf_rd_data;
  logic                  rf_wr_en;
  vv_data_pkg::rf_addr_t rf_wr_addr;
  vv_data_pkg::vector_t  rf_wr_data;

  // Per-chain configuration
  vv_firmware_store #(
    .config_unit_id (config_unit_id)
  ) u_firmware_store (
    .clk         (clk),
    .reset       (reset),
    .tracing     (tracing),
    .config_id   (config_id),
    .config_data (config_data),
    .chain_id    (beat_in.chain_id),
    .entry       (entry)
  );

  // Second operand storage
  vv_register_file u_register_file (
    .clk     (clk),
    .reset   (reset),
    .rd_addr (rf_rd_addr),
    .rd_data (rf_rd_data),
    .wr_en   (rf_wr_en),
    .wr_addr (rf_wr_addr),
    .wr_data (rf_wr_data)
  );

  vv_alu_datapath u_alu_datapath (
    .clk        (clk),
    .reset      (reset),
    .tracing    (tracing),
    .beat_in    (beat_in),
    .entry      (entry),
    .rf_rd_addr (rf_rd_addr),
    .rf_rd_data (rf_rd_data),
    .rf_wr_en   (rf_wr_en),
    .rf_wr_addr (rf_wr_addr),
    .rf_wr_data (rf_wr_data),
    .beat_out   (beat_out)
  );

endmodule

// ==== source/vv_data_pkg.sv ====
//------------------
// Vector data definitions
// Lane and vector sizes, the stream beat and the
// vector register file address type
//------------------

package vv_data_pkg;

  //------------------
  // Vector shape
  //------------------

  // Number of elements per vector
  localparam int lanes = 8;

  // Width of one element
  localparam int lane_width = 32;

  // Register file entries
  localparam int rf_depth = 8;

  // Chain tag width carried on each beat, sets the number of chains
  localparam int chain_bits = 2;

  typedef logic [$clog2(rf_depth)-1:0] rf_addr_t;

  typedef logic [lanes-1:0][lane_width-1:0] vector_t;

  //------------------
  // Stream beat
  //------------------

  // Bit 0 is the inner frame level, bit 1 the outer one
  typedef struct packed {
    logic [1:0] eof;
    logic [1:0] bof;
  } frame_flags_t;

  typedef struct packed {
    logic                  valid;
    logic [chain_bits-1:0] chain_id;
    frame_flags_t          flags;
    vector_t               data;
  } vv_beat_t;

endpackage

// ==== source/vv_firmware_pkg.sv ====
//------------------
// ALU firmware definitions
// Opcodes, frame conditions, the per-chain firmware
// entry and the configuration bus constants
//------------------

package vv_firmware_pkg;

  localparam int max_chains = 1 << vv_data_pkg::chain_bits;

  typedef logic [vv_data_pkg::chain_bits-1:0] chain_id_t;

  // Fields per chain: op, addr_rd, cond, cache, cache_addr
  localparam int config_fields = 5;
  localparam int config_bytes = config_fields * max_chains;

  // Codes above op_max also select max
  typedef enum logic [7:0] {
    op_pass = 8'd0,
    op_add  = 8'd1,
    op_mul  = 8'd2,
    op_sub  = 8'd3,
    op_max  = 8'd4
  } vv_op_e;

  // Codes above cond_outer_not_first never hold
  typedef enum logic [7:0] {
    cond_none            = 8'd0,
    cond_last            = 8'd1,
    cond_not_last        = 8'd2,
    cond_first           = 8'd3,
    cond_not_first       = 8'd4,
    cond_outer_last      = 8'd5,
    cond_outer_not_last  = 8'd6,
    cond_outer_first     = 8'd7,
    cond_outer_not_first = 8'd8
  } vv_cond_e;

  typedef struct packed {
    vv_op_e                op;
    vv_data_pkg::rf_addr_t addr_rd;
    vv_cond_e              cond;
    logic                  cache;
    vv_data_pkg::rf_addr_t cache_addr;
  } firmware_entry_t;

endpackage

// ==== source/vv_firmware_store.sv ====
//------------------
// Firmware store
// Per-chain firmware table loaded byte by byte from the
// configuration bus, with a zero-cycle lookup by chain
//------------------

module vv_firmware_store #(
  parameter logic [7:0] config_unit_id = 8'd0
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            tracing,
  input  logic [7:0]                      config_id,
  input  logic [7:0]                      config_data,
  input  vv_firmware_pkg::chain_id_t      chain_id,
  output vv_firmware_pkg::firmware_entry_t entry
);

  vv_firmware_pkg::firmware_entry_t fw_table [vv_firmware_pkg::max_chains];

  // Counts up to config_bytes and then sticks there
  logic [$clog2(vv_firmware_pkg::config_bytes + 1)-1:0] byte_count;

  logic                       id_match;
  logic                       load_byte;
  logic [2:0]                 field_sel;
  vv_firmware_pkg::chain_id_t chain_sel;

  assign id_match  = !tracing && (config_id == config_unit_id);
  assign load_byte = id_match && (byte_count < vv_firmware_pkg::config_bytes);

  // Byte k lands in field k / max_chains of chain k % max_chains
  assign field_sel = 3'(byte_count / vv_firmware_pkg::max_chains);
  assign chain_sel = vv_firmware_pkg::chain_id_t'(byte_count % vv_firmware_pkg::max_chains);

  //------------------
  // Byte counter
  //------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      byte_count <= '0;
    end else if (!tracing) begin
      if (!id_match) begin
        byte_count <= '0;
      end else if (load_byte) begin
        byte_count <= byte_count + 1'b1;
      end
    end
  end

  //------------------
  // Table write
  //------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < vv_firmware_pkg::max_chains; i++) begin
        fw_table[i] <= '{op: vv_firmware_pkg::op_pass, addr_rd: '0,
                         cond: vv_firmware_pkg::cond_none, cache: 1'b0, cache_addr: '0};
      end
    end else if (load_byte) begin
      case (field_sel)
        3'd0: fw_table[chain_sel].op <= vv_firmware_pkg::vv_op_e'(config_data);
        3'd1: fw_table[chain_sel].addr_rd <= vv_data_pkg::rf_addr_t'(config_data);
        3'd2: fw_table[chain_sel].cond <= vv_firmware_pkg::vv_cond_e'(config_data);
        3'd3: fw_table[chain_sel].cache <= config_data[0];
        default: fw_table[chain_sel].cache_addr <= vv_data_pkg::rf_addr_t'(config_data);
      endcase
    end
  end

  // Lookup for the incoming beat
  assign entry = fw_table[chain_id];

  // A load never runs past the end of the table
  assert property (@(posedge clk) disable iff (reset)
    byte_count <= vv_firmware_pkg::config_bytes);

endmodule

// ==== source/vv_register_file.sv ====
//------------------
// Vector register file
// One registered read port and one write port,
// all entries cleared on reset
//------------------

module vv_register_file (
  input  logic                  clk,
  input  logic                  reset,
  input  vv_data_pkg::rf_addr_t rd_addr,
  output vv_data_pkg::vector_t  rd_data,
  input  logic                  wr_en,
  input  vv_data_pkg::rf_addr_t wr_addr,
  input  vv_data_pkg::vector_t  wr_data
);

  vv_data_pkg::vector_t mem [vv_data_pkg::rf_depth];

  //------------------
  // Write port
  //------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < vv_data_pkg::rf_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //------------------
  // Read port
  //------------------
  // A read that collides with a write returns the old contents,
  // the datapath forwards around this
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // Write address must be known whenever a write is requested
  assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !$isunknown(wr_addr));

endmodule

// ==== src.f ====
source/vv_data_pkg.sv
source/vv_firmware_pkg.sv
source/vv_firmware_store.sv
source/vv_register_file.sv
source/vv_alu_datapath.sv
source/vv_alu_top.sv
verification/vv_alu_tb.sv

// ==== verification/vv_alu_tb.sv ====
//------------------
// Vector ALU testbench
// Random firmware loads and beats checked against a
// cycle model of the table, register file and pipeline
//------------------

module vv_alu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [7:0] unit_id = 8'h3a;
  localparam int n_phases = 5;
  localparam int load_cycles_max = 60;
  localparam int beats_per_phase = 800;
  // Every phase at its longest, plus margin for reset and drain
  localparam int timeout_cycles = n_phases * (load_cycles_max + beats_per_phase) + 1700;

  typedef struct packed {
    logic [7:0]            op;
    vv_data_pkg::rf_addr_t addr_rd;
    logic [7:0]            cond;
    logic                  cache;
    vv_data_pkg::rf_addr_t cache_addr;
  } model_entry_t;

  typedef struct packed {
    logic                       valid;
    vv_firmware_pkg::chain_id_t chain_id;
    vv_data_pkg::frame_flags_t  flags;
    vv_data_pkg::vector_t       data;
    model_entry_t               ent;
  } model_item_t;

  logic                  clk;
  logic                  reset;
  logic                  tracing;
  logic [7:0]            config_id;
  logic [7:0]            config_data;
  vv_data_pkg::vv_beat_t beat_in;
  vv_data_pkg::vv_beat_t beat_out;

  //------------------
  // Model state
  //------------------
  model_entry_t          m_table [vv_firmware_pkg::max_chains];
  vv_data_pkg::vector_t  m_rf [vv_data_pkg::rf_depth];
  int                    m_count;
  model_item_t           m_stage;
  vv_data_pkg::vv_beat_t exp_out;
  logic                  last_wr;
  vv_data_pkg::rf_addr_t last_wr_addr;

  logic [31:0] rng_state;
  int          cycle_count = 0;
  int          n_forward = 0;
  int          n_writes = 0;
  int          err_count = 0;

  vv_alu_top #(
    .config_unit_id (unit_id)
  ) u_dut (
    .clk         (clk),
    .reset       (reset),
    .tracing     (tracing),
    .config_id   (config_id),
    .config_data (config_data),
    .beat_in     (beat_in),
    .beat_out    (beat_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Extremes show up often to hit wraparound
  function automatic logic [31:0] rand_lane();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0: return 32'h0;
      3'd1: return 32'hffff_ffff;
      3'd2: return 32'h8000_0000;
      3'd3: return 32'h7fff_ffff;
      3'd4: return {28'h0, r[11:8]};
      default: return next_rand();
    endcase
  endfunction

  function automatic vv_data_pkg::vv_beat_t make_beat();
    vv_data_pkg::vv_beat_t b;
    logic [31:0] r;
    r = next_rand();
    b.valid    = (r[2:0] != 3'd0);
    b.chain_id = r[4:3];
    b.flags    = r[8:5];
    for (int i = 0; i < vv_data_pkg::lanes; i++)
      b.data[i] = rand_lane();
    return b;
  endfunction

  // Op codes 0 to 5, cond codes 0 to 10, addresses mostly 0 or 1
  function automatic logic [7:0] config_byte(input int k);
    logic [31:0] r;
    r = next_rand();
    case (k / vv_firmware_pkg::max_chains)
      0: return 8'(r[15:8] % 6);
      2: return 8'(r[15:8] % 11);
      3: return r[15:8];
      default: return r[3] ? {r[15:11], 2'b00, r[4]} : r[15:8];
    endcase
  endfunction

  function automatic logic cond_true(input logic [7:0] cond,
                                     input vv_data_pkg::frame_flags_t f);
    case (cond)
      8'd0: return 1'b1;
      8'd1: return f.eof[0];
      8'd2: return !f.eof[0];
      8'd3: return f.bof[0];
      8'd4: return !f.bof[0];
      8'd5: return f.eof[1];
      8'd6: return !f.eof[1];
      8'd7: return f.bof[1];
      8'd8: return !f.bof[1];
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] lane_op(input logic [7:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] prod;
    prod = {32'h0, a} * {32'h0, b};
    case (op)
      8'd0: return a;
      8'd1: return a + b;
      8'd2: return prod[31:0];
      8'd3: return a - b;
      default: return (a > b) ? a : b;
    endcase
  endfunction

  // Model state as left by a reset of the DUT
  function automatic void clear_model();
    for (int i = 0; i < vv_firmware_pkg::max_chains; i++)
      m_table[i] = '0;
    for (int i = 0; i < vv_data_pkg::rf_depth; i++)
      m_rf[i] = '0;
    m_count = 0;
    m_stage = '0;
    exp_out = '0;
    last_wr = 1'b0;
    last_wr_addr = '0;
  endfunction

  // One model clock edge in the order output, write-back, capture and config
  function automatic void model_step(input logic t, input logic [7:0] id,
                                     input logic [7:0] data, input vv_data_pkg::vv_beat_t b);
    vv_data_pkg::vector_t operand;
    vv_data_pkg::vector_t result;
    int field;
    int ch;
    operand = m_rf[m_stage.ent.addr_rd];
    if (m_stage.valid && last_wr && last_wr_addr == m_stage.ent.addr_rd)
      n_forward++;
    for (int i = 0; i < vv_data_pkg::lanes; i++) begin
      result[i] = cond_true(m_stage.ent.cond, m_stage.flags) ?
                  lane_op(m_stage.ent.op, m_stage.data[i], operand[i]) : m_stage.data[i];
    end
    exp_out.valid    = m_stage.valid && t;
    exp_out.chain_id = m_stage.chain_id;
    exp_out.flags    = m_stage.flags;
    exp_out.data     = result;
    last_wr      = m_stage.valid && m_stage.ent.cache;
    last_wr_addr = m_stage.ent.cache_addr;
    if (last_wr) begin
      m_rf[last_wr_addr] = result;
      n_writes++;
    end
    m_stage.valid    = b.valid && t;
    m_stage.chain_id = b.chain_id;
    m_stage.flags    = b.flags;
    m_stage.data     = b.data;
    m_stage.ent      = m_table[b.chain_id];
    if (!t) begin
      if (id != unit_id) begin
        m_count = 0;
      end else if (m_count < vv_firmware_pkg::config_bytes) begin
        field = m_count / vv_firmware_pkg::max_chains;
        ch    = m_count % vv_firmware_pkg::max_chains;
        case (field)
          0: m_table[ch].op = data;
          1: m_table[ch].addr_rd = data[2:0];
          2: m_table[ch].cond = data;
          3: m_table[ch].cache = data[0];
          default: m_table[ch].cache_addr = data[2:0];
        endcase
        m_count++;
      end
    end
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first mismatch");
  endtask

  // Three cycles of reset with idle inputs, then the outputs must be quiet
  task automatic apply_reset();
    reset       <= 1'b1;
    tracing     <= 1'b0;
    config_id   <= ~unit_id;
    config_data <= 8'h00;
    beat_in     <= '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    clear_model();
    @(negedge clk);
    assert (beat_out.valid === 1'b0 && u_dut.rf_wr_en === 1'b0) else begin
      $display("Output valid or register file write enable is high right after reset");
      stop_on_error();
    end
  endtask

  task automatic check_output(input vv_data_pkg::vv_beat_t due);
    assert (beat_out.valid === due.valid) else begin
      $display("ERR t=%0t beat_out.valid got %b exp %b", $time, beat_out.valid, due.valid);
      stop_on_error();
    end
    if (due.valid) begin
      assert (beat_out.chain_id === due.chain_id) else begin
        $display("ERR t=%0t beat_out.chain_id got %0d exp %0d", $time, beat_out.chain_id,
                 due.chain_id);
        stop_on_error();
      end
      assert (beat_out.flags === due.flags) else begin
        $display("ERR t=%0t beat_out.flags got %h exp %h", $time, beat_out.flags, due.flags);
        stop_on_error();
      end
      for (int i = 0; i < vv_data_pkg::lanes; i++) begin
        assert (beat_out.data[i] === due.data[i]) else begin
          $display("ERR t=%0t beat_out.data[%0d] got %h exp %h", $time, i, beat_out.data[i],
                   due.data[i]);
          stop_on_error();
        end
      end
    end
  endtask

  // Drive one cycle, advance the model and check the output of this edge
  task automatic run_cycle(input logic t, input logic [7:0] id, input logic [7:0] data,
                           input vv_data_pkg::vv_beat_t b);
    vv_data_pkg::vv_beat_t due;
    @(posedge clk);
    tracing     <= t;
    config_id   <= id;
    config_data <= data;
    beat_in     <= b;
    due = exp_out;
    model_step(t, id, data, b);
    @(negedge clk);
    check_output(due);
  endtask

  task automatic load_phase();
    logic [31:0] r;
    logic [7:0]  other_id;
    r = next_rand();
    other_id = unit_id ^ (8'h01 << r[2:0]);
    run_cycle(1'b0, other_id, r[15:8], make_beat());
    // Partial load cut off by another unit's id
    if (r[3]) begin
      for (int k = 0; k < 1 + int'(r[23:16]) % 19; k++)
        run_cycle(1'b0, unit_id, config_byte(k), make_beat());
      run_cycle(1'b0, other_id, r[31:24], make_beat());
    end
    for (int k = 0; k < vv_firmware_pkg::config_bytes; k++)
      run_cycle(1'b0, unit_id, config_byte(k), make_beat());
    for (int k = 0; k < int'(r[6:4]) % 5; k++)
      run_cycle(1'b0, unit_id, 8'(next_rand()), make_beat());
  endtask

  // Mostly tracing, with short drops of tracing mid-stream
  task automatic trace_phase(input int n);
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      r = next_rand();
      if (r[3:0] == 4'd0)
        run_cycle(1'b0, r[4] ? unit_id : unit_id ^ 8'h80, r[15:8], make_beat());
      else
        run_cycle(1'b1, r[23:16], r[15:8], make_beat());
    end
  endtask

  //------------------
  // Timeout
  //------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  //------------------
  // Main sequence
  //------------------
  initial begin
    rng_state = 32'd58;
    apply_reset();
    for (int p = 0; p < n_phases; p++) begin
      // Second reset with written entries, table and registers must come back cleared
      if (p == n_phases / 2) begin
        repeat (2) run_cycle(1'b1, ~unit_id, 8'h00, '0);
        @(posedge clk);
        apply_reset();
        trace_phase(16);
      end
      load_phase();
      trace_phase(beats_per_phase);
    end
    repeat (3) run_cycle(1'b1, ~unit_id, 8'h00, '0);
    assert (n_forward > 0 && n_writes > 0) else begin
      $display("No register file write-back or no forwarded operand was exercised");
      err_count++;
    end
    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "coverage incomplete");
    end
  end

endmodule
